/* source/csr_macros.svh */
// Width, reset values, write masks and bit positions for the machine CSR unit; include where needed
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_XLEN 64

// Reset values
`define MSTATUS_RST 64'h0000_0000_0000_1880    // MPP = machine, MPIE = 1
`define MIE_RST     64'h0000_0000_0000_0888

// Writable mstatus bits: SD, XS, FS, MPP, MPIE, MIE
`define MSTATUS_WMASK 64'h8000_0000_0001_F888

// RV64I: MXL = 2, extension I only
`define MISA_VAL 64'h8000_0000_0000_0100

// mstatus field positions
`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7
`define MSTATUS_MPP_LSB  11
`define MSTATUS_FS_LSB   13
`define MSTATUS_XS_LSB   15
`define MSTATUS_SD_BIT   63

// mip / mie bit positions of the machine interrupts
`define MIP_MSIP_BIT 3
`define MIP_MTIP_BIT 7
`define MIP_MEIP_BIT 11

`endif

/* source/csr_pkg.sv */
// Shared CSR addresses, trap cause codes and the register word type; referenced as csr_pkg::name
`include "csr_macros.svh"

package csr_pkg;

  typedef logic [`CSR_XLEN-1:0] word_t;

  typedef enum logic [11:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MISA      = 12'h301,
    CSR_MIE       = 12'h304,
    CSR_MTVEC     = 12'h305,
    CSR_MSCRATCH  = 12'h340,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MTVAL     = 12'h343,
    CSR_MIP       = 12'h344,
    CSR_MCYCLE    = 12'hB00,
    CSR_MVENDORID = 12'hF11,
    CSR_MARCHID   = 12'hF12,
    CSR_MIMPID    = 12'hF13,
    CSR_MHARTID   = 12'hF14
  } csr_addr_e;

  // Interrupt and exception codes overlap, excp_is_irq tells them apart
  typedef logic [5:0] cause_e;

  localparam cause_e CAUSE_INSN_MISALIGN  = 6'd0;
  localparam cause_e CAUSE_INSN_FAULT     = 6'd1;
  localparam cause_e CAUSE_ILLEGAL_INSN   = 6'd2;
  localparam cause_e CAUSE_BREAKPOINT     = 6'd3;
  localparam cause_e CAUSE_LOAD_MISALIGN  = 6'd4;
  localparam cause_e CAUSE_LOAD_FAULT     = 6'd5;
  localparam cause_e CAUSE_STORE_MISALIGN = 6'd6;
  localparam cause_e CAUSE_STORE_FAULT    = 6'd7;
  localparam cause_e CAUSE_ECALL_M        = 6'd11;

  localparam cause_e CAUSE_IRQ_M_SOFT  = 6'd3;
  localparam cause_e CAUSE_IRQ_M_TIMER = 6'd7;
  localparam cause_e CAUSE_IRQ_M_EXT   = 6'd11;

endpackage

/* source/irq_sync.sv */
// Two-flop synchronizers for the machine interrupt lines, producing the mip value for csr_unit
`timescale 1ns/1ps
`include "csr_macros.svh"

module irq_sync (
  input  logic           clk,
  input  logic           rst,
  input  logic [2:0]     irq_lines,   // [0] software, [1] timer, [2] external
  output csr_pkg::word_t mip
);

  logic [2:0] sync_meta;   // First stage, may go metastable
  logic [2:0] sync_out;

  always_ff @(posedge clk) begin
    if (rst) begin
      sync_meta <= '0;
      sync_out  <= '0;
    end else begin
      sync_meta <= irq_lines;
      sync_out  <= sync_meta;
    end
  end

  // Place each line on its architectural mip bit
  always_comb begin
    mip = '0;
    mip[`MIP_MSIP_BIT] = sync_out[0];
    mip[`MIP_MTIP_BIT] = sync_out[1];
    mip[`MIP_MEIP_BIT] = sync_out[2];
  end

endmodule

/* source/trap_ctrl.sv */
// Computes trap entry and mret CSR updates, the redirect PC and the interrupt request for csr_unit
`timescale 1ns/1ps
`include "csr_macros.svh"

module trap_ctrl (
  input  logic            excp_enter,
  input  logic            excp_exit,
  input  csr_pkg::cause_e excp_cause,
  input  logic            excp_is_irq,
  input  csr_pkg::word_t  excp_pc,
  input  csr_pkg::word_t  excp_tval,
  input  csr_pkg::word_t  mstatus,
  input  csr_pkg::word_t  mtvec,
  input  csr_pkg::word_t  mepc,
  input  csr_pkg::word_t  mie,
  input  csr_pkg::word_t  mip,
  output logic            trap_wr,
  output logic            trap_enter,
  output csr_pkg::word_t  new_mstatus,
  output csr_pkg::word_t  new_mepc,
  output csr_pkg::word_t  new_mcause,
  output csr_pkg::word_t  new_mtval,
  output csr_pkg::word_t  trap_pc,
  output logic            irq_req
);

  csr_pkg::word_t vec_base;
  csr_pkg::word_t vec_offset;

  assign trap_wr    = excp_enter | excp_exit;
  assign trap_enter = excp_enter;

  assign new_mepc   = excp_pc;
  assign new_mtval  = excp_tval;
  assign new_mcause = {excp_is_irq, {(`CSR_XLEN-7){1'b0}}, excp_cause};  // MSB flags interrupts

  // Interrupt-enable stack push on entry, pop on mret
  always_comb begin
    new_mstatus = mstatus;
    if (excp_enter) begin
      new_mstatus[`MSTATUS_MPIE_BIT]   = mstatus[`MSTATUS_MIE_BIT];
      new_mstatus[`MSTATUS_MIE_BIT]    = 1'b0;
      new_mstatus[`MSTATUS_MPP_LSB +: 2] = 2'b11;   // Only machine mode exists
    end else if (excp_exit) begin
      new_mstatus[`MSTATUS_MIE_BIT]  = mstatus[`MSTATUS_MPIE_BIT];
      new_mstatus[`MSTATUS_MPIE_BIT] = 1'b1;
    end
  end

  // Vectored mode sends interrupts to base + 4 * cause
  assign vec_base = {mtvec[`CSR_XLEN-1:2], 2'b00};
  assign vec_offset = (mtvec[1:0] == 2'b01 && excp_is_irq) ?
                      {{(`CSR_XLEN-8){1'b0}}, excp_cause, 2'b00} : '0;

  always_comb begin
    if (excp_enter) begin
      trap_pc = vec_base + vec_offset;
    end else if (excp_exit) begin
      trap_pc = mepc;
    end else begin
      trap_pc = '0;
    end
  end

  // Pending and enabled, with the global machine enable on
  assign irq_req = (|(mip & mie)) && mstatus[`MSTATUS_MIE_BIT];

endmodule

/* source/csr_file.sv */
// Machine CSR storage with write masking and same-cycle read bypass, instantiated inside csr_unit
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_file (
  input  logic           clk,
  input  logic           rst,
  input  logic           csr_rd_ena,
  input  logic [11:0]    csr_rd_addr,
  output csr_pkg::word_t csr_rd_data,
  input  logic           csr_wr_ena,
  input  logic [11:0]    csr_wr_addr,
  input  csr_pkg::word_t csr_wr_data,
  input  logic           trap_wr,      // Trap entry or mret updates mstatus
  input  logic           trap_enter,   // Trap entry also loads mepc, mcause, mtval
  input  csr_pkg::word_t new_mstatus,
  input  csr_pkg::word_t new_mepc,
  input  csr_pkg::word_t new_mcause,
  input  csr_pkg::word_t new_mtval,
  input  csr_pkg::word_t mip,
  output csr_pkg::word_t mstatus,
  output csr_pkg::word_t mtvec,
  output csr_pkg::word_t mepc,
  output csr_pkg::word_t mie
);

  csr_pkg::word_t mscratch;
  csr_pkg::word_t mcause;
  csr_pkg::word_t mtval;
  csr_pkg::word_t mcycle;

  logic wr_mstatus;
  logic wr_mie;
  logic wr_mtvec;
  logic wr_mscratch;
  logic wr_mepc;
  logic wr_mcause;
  logic wr_mtval;
  logic wr_mcycle;

  csr_pkg::word_t sw_mstatus;     // Software write value, legalized
  csr_pkg::word_t trap_mstatus;   // Trap update value, legalized
  csr_pkg::word_t mcycle_inc;
  csr_pkg::word_t rd_mux;

  // Keep only writable bits and derive SD from the FS and XS dirty states
  function automatic csr_pkg::word_t mstatus_legal(input csr_pkg::word_t value);
    csr_pkg::word_t masked;
    masked = value & `MSTATUS_WMASK;
    masked[`MSTATUS_SD_BIT] = (masked[`MSTATUS_FS_LSB +: 2] == 2'b11) ||
                              (masked[`MSTATUS_XS_LSB +: 2] == 2'b11);
    return masked;
  endfunction

  assign wr_mstatus  = csr_wr_ena && (csr_wr_addr == csr_pkg::CSR_MSTATUS);
  assign wr_mie      = csr_wr_ena && (csr_wr_addr == csr_pkg::CSR_MIE);
  assign wr_mtvec    = csr_wr_ena && (csr_wr_addr == csr_pkg::CSR_MTVEC);
  assign wr_mscratch = csr_wr_ena && (csr_wr_addr == csr_pkg::CSR_MSCRATCH);
  assign wr_mepc     = csr_wr_ena && (csr_wr_addr == csr_pkg::CSR_MEPC);
  assign wr_mcause   = csr_wr_ena && (csr_wr_addr == csr_pkg::CSR_MCAUSE);
  assign wr_mtval    = csr_wr_ena && (csr_wr_addr == csr_pkg::CSR_MTVAL);
  assign wr_mcycle   = csr_wr_ena && (csr_wr_addr == csr_pkg::CSR_MCYCLE);

  assign sw_mstatus   = mstatus_legal(csr_wr_data);
  assign trap_mstatus = mstatus_legal(new_mstatus);
  assign mcycle_inc   = mcycle + 1'b1;

  // Registers touched by traps; trap updates win over software writes
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= `MSTATUS_RST;
      mepc    <= '0;
      mcause  <= '0;
      mtval   <= '0;
    end else begin
      if (trap_wr) begin
        mstatus <= trap_mstatus;
      end else if (wr_mstatus) begin
        mstatus <= sw_mstatus;
      end
      if (trap_enter) begin
        mepc   <= new_mepc;
        mcause <= new_mcause;
        mtval  <= new_mtval;
      end else begin
        if (wr_mepc) mepc <= csr_wr_data;
        if (wr_mcause) mcause <= csr_wr_data;
        if (wr_mtval) mtval <= csr_wr_data;
      end
    end
  end

  // Software-only registers and the cycle counter
  always_ff @(posedge clk) begin
    if (rst) begin
      mie      <= `MIE_RST;
      mtvec    <= '0;
      mscratch <= '0;
      mcycle   <= '0;
    end else begin
      if (wr_mie) mie <= csr_wr_data;
      if (wr_mtvec) mtvec <= csr_wr_data;
      if (wr_mscratch) mscratch <= csr_wr_data;
      mcycle <= wr_mcycle ? csr_wr_data : mcycle_inc;
    end
  end

  always_comb begin
    rd_mux = '0;
    case (csr_rd_addr)
      csr_pkg::CSR_MSTATUS:  rd_mux = trap_wr ? trap_mstatus : (wr_mstatus ? sw_mstatus : mstatus);
      csr_pkg::CSR_MISA:     rd_mux = `MISA_VAL;
      csr_pkg::CSR_MIE:      rd_mux = wr_mie ? csr_wr_data : mie;
      csr_pkg::CSR_MTVEC:    rd_mux = wr_mtvec ? csr_wr_data : mtvec;
      csr_pkg::CSR_MSCRATCH: rd_mux = wr_mscratch ? csr_wr_data : mscratch;
      csr_pkg::CSR_MEPC:     rd_mux = trap_enter ? new_mepc : (wr_mepc ? csr_wr_data : mepc);
      csr_pkg::CSR_MCAUSE:   rd_mux = trap_enter ? new_mcause : (wr_mcause ? csr_wr_data : mcause);
      csr_pkg::CSR_MTVAL:    rd_mux = trap_enter ? new_mtval : (wr_mtval ? csr_wr_data : mtval);
      csr_pkg::CSR_MIP:      rd_mux = mip;   // Live from the synchronizers
      csr_pkg::CSR_MCYCLE:   rd_mux = wr_mcycle ? csr_wr_data : mcycle_inc;
      // ID registers read as zero
      csr_pkg::CSR_MVENDORID, csr_pkg::CSR_MARCHID,
      csr_pkg::CSR_MIMPID, csr_pkg::CSR_MHARTID: rd_mux = '0;
      default:               rd_mux = '0;
    endcase
  end

  assign csr_rd_data = (csr_rd_ena && !rst) ? rd_mux : '0;

endmodule

/* source/csr_unit.sv */
// Machine-mode CSR unit top level, wiring interrupt sync, trap control and the register file
`timescale 1ns/1ps

module csr_unit (
  input  logic            clk,
  input  logic            rst,
  input  logic            csr_rd_ena,
  input  logic [11:0]     csr_rd_addr,
  output csr_pkg::word_t  csr_rd_data,
  input  logic            csr_wr_ena,
  input  logic [11:0]     csr_wr_addr,
  input  csr_pkg::word_t  csr_wr_data,
  input  logic            excp_enter,
  input  logic            excp_exit,
  input  csr_pkg::cause_e excp_cause,
  input  logic            excp_is_irq,
  input  csr_pkg::word_t  excp_pc,
  input  csr_pkg::word_t  excp_tval,
  input  logic [2:0]      irq_lines,
  output csr_pkg::word_t  trap_pc,
  output logic            irq_req
);

  csr_pkg::word_t mip;
  csr_pkg::word_t mstatus;
  csr_pkg::word_t mtvec;
  csr_pkg::word_t mepc;
  csr_pkg::word_t mie;
  logic           trap_wr;
  logic           trap_enter;
  csr_pkg::word_t new_mstatus;
  csr_pkg::word_t new_mepc;
  csr_pkg::word_t new_mcause;
  csr_pkg::word_t new_mtval;

  irq_sync i_irq_sync (
    .clk       (clk),
    .rst       (rst),
    .irq_lines (irq_lines),
    .mip       (mip)
  );

  // Trap control sees the stored state, not the bypassed one
  trap_ctrl i_trap_ctrl (
    .excp_enter  (excp_enter),
    .excp_exit   (excp_exit),
    .excp_cause  (excp_cause),
    .excp_is_irq (excp_is_irq),
    .excp_pc     (excp_pc),
    .excp_tval   (excp_tval),
    .mstatus     (mstatus),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .mie         (mie),
    .mip         (mip),
    .trap_wr     (trap_wr),
    .trap_enter  (trap_enter),
    .new_mstatus (new_mstatus),
    .new_mepc    (new_mepc),
    .new_mcause  (new_mcause),
    .new_mtval   (new_mtval),
    .trap_pc     (trap_pc),
    .irq_req     (irq_req)
  );

  csr_file i_csr_file (
    .clk         (clk),
    .rst         (rst),
    .csr_rd_ena  (csr_rd_ena),
    .csr_rd_addr (csr_rd_addr),
    .csr_rd_data (csr_rd_data),
    .csr_wr_ena  (csr_wr_ena),
    .csr_wr_addr (csr_wr_addr),
    .csr_wr_data (csr_wr_data),
    .trap_wr     (trap_wr),
    .trap_enter  (trap_enter),
    .new_mstatus (new_mstatus),
    .new_mepc    (new_mepc),
    .new_mcause  (new_mcause),
    .new_mtval   (new_mtval),
    .mip         (mip),
    .mstatus     (mstatus),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .mie         (mie)
  );

endmodule

/* verification/csr_unit_checker.sv */
// Concurrent assertions on trap, counter and read port behavior, bound into the CSR unit
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_unit_checker (
  input logic           clk,
  input logic           rst,
  input logic           excp_enter,
  input logic           excp_exit,
  input logic           csr_wr_ena,
  input logic [11:0]    csr_wr_addr,
  input csr_pkg::word_t csr_rd_data,
  input csr_pkg::word_t mstatus,
  input csr_pkg::word_t mcycle
);

  int fails;   // Count of failed assertions

  initial fails = 0;

  // Entry clears the global interrupt enable
  assert property (@(posedge clk) disable iff (rst)
    excp_enter |=> !mstatus[`MSTATUS_MIE_BIT])
    else begin
      fails++;
      $error("mstatus.MIE still set one cycle after trap entry");
    end

  // Counter advances by one unless software writes it
  assert property (@(posedge clk) disable iff (rst)
    !(csr_wr_ena && (csr_wr_addr == csr_pkg::CSR_MCYCLE)) |=> (mcycle == $past(mcycle) + 64'd1))
    else begin
      fails++;
      $error("mcycle did not advance by one");
    end

  assert property (@(posedge clk) disable iff (rst) !(excp_enter && excp_exit))
    else begin
      fails++;
      $error("trap entry and mret raised in the same cycle");
    end

  assert property (@(posedge clk) rst |-> (csr_rd_data == '0))
    else begin
      fails++;
      $error("csr_rd_data not zero while in reset");
    end

endmodule

// Mcycle lives inside the register file
bind csr_unit csr_unit_checker i_csr_unit_checker (
  .clk         (clk),
  .rst         (rst),
  .excp_enter  (excp_enter),
  .excp_exit   (excp_exit),
  .csr_wr_ena  (csr_wr_ena),
  .csr_wr_addr (csr_wr_addr),
  .csr_rd_data (csr_rd_data),
  .mstatus     (mstatus),
  .mcycle      (i_csr_file.mcycle)
);

/* verification/csr_unit_tb.sv */
// Table-driven testbench for csr_unit, expected values come from a shadow register model
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_unit_tb;

  typedef enum logic [2:0] {OP_READ, OP_WRITE, OP_TRAP, OP_MRET, OP_IRQ, OP_WAIT} op_e;

  typedef struct packed {
    op_e            op;
    logic [11:0]    addr;
    csr_pkg::word_t data;   // Write data, cause code or irq lines
    logic           is_irq;
    csr_pkg::word_t pc;
    csr_pkg::word_t tval;
    csr_pkg::word_t exp;    // csr_rd_data, trap_pc or irq_req
  } step_t;

  logic            clk;
  logic            rst;
  logic            csr_rd_ena;
  logic [11:0]     csr_rd_addr;
  csr_pkg::word_t  csr_rd_data;
  logic            csr_wr_ena;
  logic [11:0]     csr_wr_addr;
  csr_pkg::word_t  csr_wr_data;
  logic            excp_enter;
  logic            excp_exit;
  csr_pkg::cause_e excp_cause;
  logic            excp_is_irq;
  csr_pkg::word_t  excp_pc;
  csr_pkg::word_t  excp_tval;
  logic [2:0]      irq_lines;
  csr_pkg::word_t  trap_pc;
  logic            irq_req;

  step_t steps[$];
  integer seed;
  int errors;
  int checks;
  int cycles;
  int limit;

  // Shadow model of the architectural state
  csr_pkg::word_t m_mstatus;
  csr_pkg::word_t m_mie;
  csr_pkg::word_t m_mtvec;
  csr_pkg::word_t m_mscratch;
  csr_pkg::word_t m_mepc;
  csr_pkg::word_t m_mcause;
  csr_pkg::word_t m_mtval;
  csr_pkg::word_t m_mcycle;
  logic [2:0]     m_lines;
  logic [2:0]     m_sync1;
  logic [2:0]     m_sync2;

  logic [11:0] probe_addrs [13] = '{
    csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MIE, csr_pkg::CSR_MISA, csr_pkg::CSR_MTVEC,
    csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE, csr_pkg::CSR_MTVAL,
    csr_pkg::CSR_MVENDORID, csr_pkg::CSR_MARCHID, csr_pkg::CSR_MIMPID, csr_pkg::CSR_MHARTID,
    12'h7C0                 // Unimplemented address
  };

  csr_unit i_csr_unit (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors + 1, i_csr_unit.i_csr_unit_checker.fails);
      $display("sim failed");
      $finish;
    end
  end

  // Writable fields only, SD set when FS or XS is dirty
  function automatic csr_pkg::word_t mstatus_view(input csr_pkg::word_t value);
    csr_pkg::word_t result;
    result = value & `MSTATUS_WMASK;
    result[63] = (&value[14:13]) | (&value[16:15]);
    return result;
  endfunction

  function automatic csr_pkg::word_t mip_view();
    csr_pkg::word_t result;
    result = '0;
    result[`MIP_MSIP_BIT] = m_sync2[0];
    result[`MIP_MTIP_BIT] = m_sync2[1];
    result[`MIP_MEIP_BIT] = m_sync2[2];
    return result;
  endfunction

  function automatic csr_pkg::word_t model_read(input logic [11:0] addr);
    case (addr)
      csr_pkg::CSR_MSTATUS:  return m_mstatus;
      csr_pkg::CSR_MISA:     return `MISA_VAL;
      csr_pkg::CSR_MIE:      return m_mie;
      csr_pkg::CSR_MTVEC:    return m_mtvec;
      csr_pkg::CSR_MSCRATCH: return m_mscratch;
      csr_pkg::CSR_MEPC:     return m_mepc;
      csr_pkg::CSR_MCAUSE:   return m_mcause;
      csr_pkg::CSR_MTVAL:    return m_mtval;
      csr_pkg::CSR_MIP:      return mip_view();
      csr_pkg::CSR_MCYCLE:   return m_mcycle + 64'd1;   // Value after this edge
      default:               return '0;
    endcase
  endfunction

  function automatic csr_pkg::word_t irq_model();
    return {63'b0, (|(mip_view() & m_mie)) && m_mstatus[`MSTATUS_MIE_BIT]};
  endfunction

  // Appends one single-cycle step and advances the shadow model past its clock edge
  task automatic add_step(input op_e op, input logic [11:0] addr, input csr_pkg::word_t data,
                          input logic is_irq, input csr_pkg::word_t pc,
                          input csr_pkg::word_t tval);
    step_t s;
    logic cycle_wr;
    cycle_wr = 1'b0;
    s.op = op;
    s.addr = addr;
    s.data = data;
    s.is_irq = is_irq;
    s.pc = pc;
    s.tval = tval;
    case (op)
      OP_READ: s.exp = model_read(addr);
      OP_WRITE: begin
        case (addr)
          csr_pkg::CSR_MSTATUS:  m_mstatus = mstatus_view(data);
          csr_pkg::CSR_MIE:      m_mie = data;
          csr_pkg::CSR_MTVEC:    m_mtvec = data;
          csr_pkg::CSR_MSCRATCH: m_mscratch = data;
          csr_pkg::CSR_MEPC:     m_mepc = data;
          csr_pkg::CSR_MCAUSE:   m_mcause = data;
          csr_pkg::CSR_MTVAL:    m_mtval = data;
          csr_pkg::CSR_MCYCLE:   cycle_wr = 1'b1;
          default: ;
        endcase
        s.exp = cycle_wr ? data : model_read(addr);
      end
      OP_TRAP: begin
        s.exp = {m_mtvec[63:2], 2'b00};
        if (m_mtvec[1:0] == 2'b01 && is_irq) s.exp = s.exp + (data << 2);
        m_mepc = pc;
        m_mcause = {is_irq, data[62:0]};
        m_mtval = tval;
        m_mstatus[`MSTATUS_MPIE_BIT] = m_mstatus[`MSTATUS_MIE_BIT];
        m_mstatus[`MSTATUS_MIE_BIT] = 1'b0;
        m_mstatus[`MSTATUS_MPP_LSB +: 2] = 2'b11;
      end
      OP_MRET: begin
        s.exp = m_mepc;
        m_mstatus[`MSTATUS_MIE_BIT] = m_mstatus[`MSTATUS_MPIE_BIT];
        m_mstatus[`MSTATUS_MPIE_BIT] = 1'b1;
      end
      OP_IRQ: begin
        s.exp = irq_model();
        m_lines = data[2:0];
      end
      default: s.exp = irq_model();
    endcase
    m_mcycle = cycle_wr ? data : m_mcycle + 64'd1;
    m_sync2 = m_sync1;
    m_sync1 = m_lines;
    steps.push_back(s);
  endtask

  task automatic drive_step(input step_t s);
    csr_rd_ena  = (s.op == OP_READ) || (s.op == OP_WRITE);   // Writes also read the bypass
    csr_rd_addr = csr_rd_ena ? s.addr : csr_pkg::CSR_MISA;   // Idle address holds a nonzero value
    csr_wr_ena  = (s.op == OP_WRITE);
    csr_wr_addr = s.addr;
    csr_wr_data = s.data;
    excp_enter  = (s.op == OP_TRAP);
    excp_exit   = (s.op == OP_MRET);
    excp_cause  = s.data[5:0];
    excp_is_irq = s.is_irq;
    excp_pc     = s.pc;
    excp_tval   = s.tval;
    if (s.op == OP_IRQ) irq_lines = s.data[2:0];
  endtask

  task automatic check_step(input int idx, input step_t s);
    checks++;
    case (s.op)
      OP_READ, OP_WRITE:
        assert (csr_rd_data == s.exp) else begin
          errors++;
          $display("MISMATCH csr_rd_data step %0d: got %h, expected %h", idx, csr_rd_data, s.exp);
        end
      OP_TRAP, OP_MRET:
        assert (trap_pc == s.exp) else begin
          errors++;
          $display("MISMATCH trap_pc step %0d: got %h, expected %h", idx, trap_pc, s.exp);
        end
      default:
        assert (irq_req == s.exp[0]) else begin
          errors++;
          $display("MISMATCH irq_req step %0d: got %h, expected %h", idx, irq_req, s.exp[0]);
        end
    endcase
    if (!csr_rd_ena) begin
      assert (csr_rd_data == '0) else begin
        errors++;
        $display("MISMATCH csr_rd_data step %0d with read off: got %h, expected %h",
                 idx, csr_rd_data, 64'h0);
      end
    end
  endtask

  initial begin
    csr_pkg::word_t rnd;
    clk = 1'b0;
    rst = 1'b1;
    drive_step('0);
    csr_rd_addr = csr_pkg::CSR_MISA;   // Nonzero register read while in reset
    irq_lines = 3'b000;
    errors = 0;
    checks = 0;
    cycles = 0;
    limit = 0;
    seed = 32'h47c1b5aa;
    m_mstatus = `MSTATUS_RST;
    m_mie = `MIE_RST;
    m_mtvec = '0;
    m_mscratch = '0;
    m_mepc = '0;
    m_mcause = '0;
    m_mtval = '0;
    m_mcycle = '0;
    m_lines = '0;
    m_sync1 = '0;
    m_sync2 = '0;

    // Reset values and an unknown address
    foreach (probe_addrs[i]) add_step(OP_READ, probe_addrs[i], '0, 1'b0, '0, '0);
    // Software writes, read back through the bypass and on the next cycle
    rnd = {$random(seed), $random(seed)};
    add_step(OP_WRITE, csr_pkg::CSR_MSCRATCH, rnd, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MSCRATCH, '0, 1'b0, '0, '0);
    rnd = {$random(seed), $random(seed)};
    add_step(OP_WRITE, csr_pkg::CSR_MTVEC, rnd, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MTVEC, '0, 1'b0, '0, '0);
    add_step(OP_WRITE, csr_pkg::CSR_MSTATUS, '1, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MSTATUS, '0, 1'b0, '0, '0);
    add_step(OP_WRITE, csr_pkg::CSR_MSTATUS, 64'h2088, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MSTATUS, '0, 1'b0, '0, '0);
    add_step(OP_WRITE, csr_pkg::CSR_MISA, '0, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MISA, '0, 1'b0, '0, '0);
    add_step(OP_WRITE, csr_pkg::CSR_MHARTID, 64'h5, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MHARTID, '0, 1'b0, '0, '0);
    add_step(OP_WRITE, csr_pkg::CSR_MEPC, 64'h8000_1234, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MEPC, '0, 1'b0, '0, '0);
    // Trap entry in direct mode
    add_step(OP_WRITE, csr_pkg::CSR_MTVEC, 64'h8000_0100, 1'b0, '0, '0);
    add_step(OP_WRITE, csr_pkg::CSR_MSTATUS, 64'h88, 1'b0, '0, '0);
    add_step(OP_TRAP, '0, csr_pkg::CAUSE_ILLEGAL_INSN, 1'b0, 64'h8000_0040, 64'hDEAD);
    add_step(OP_READ, csr_pkg::CSR_MEPC, '0, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MCAUSE, '0, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MTVAL, '0, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MSTATUS, '0, 1'b0, '0, '0);
    // Vectored mode, interrupt then exception
    add_step(OP_WRITE, csr_pkg::CSR_MTVEC, 64'h8000_0201, 1'b0, '0, '0);
    add_step(OP_TRAP, '0, csr_pkg::CAUSE_IRQ_M_TIMER, 1'b1, 64'h8000_0080, '0);
    add_step(OP_READ, csr_pkg::CSR_MCAUSE, '0, 1'b0, '0, '0);
    add_step(OP_TRAP, '0, csr_pkg::CAUSE_ECALL_M, 1'b0, 64'h8000_0090, '0);
    // mret with MPIE set, then with MPIE clear
    add_step(OP_WRITE, csr_pkg::CSR_MSTATUS, 64'h1880, 1'b0, '0, '0);
    add_step(OP_MRET, '0, '0, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MSTATUS, '0, 1'b0, '0, '0);
    add_step(OP_WRITE, csr_pkg::CSR_MSTATUS, 64'h1808, 1'b0, '0, '0);
    add_step(OP_MRET, '0, '0, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MSTATUS, '0, 1'b0, '0, '0);
    // Interrupt lines through the synchronizer and the enable rule
    add_step(OP_WRITE, csr_pkg::CSR_MIE, '0, 1'b0, '0, '0);
    add_step(OP_WRITE, csr_pkg::CSR_MSTATUS, 64'h8, 1'b0, '0, '0);
    add_step(OP_IRQ, '0, 64'h2, 1'b0, '0, '0);
    add_step(OP_WAIT, '0, '0, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MIP, '0, 1'b0, '0, '0);
    add_step(OP_WAIT, '0, '0, 1'b0, '0, '0);
    add_step(OP_WRITE, csr_pkg::CSR_MIE, 64'h80, 1'b0, '0, '0);
    add_step(OP_WAIT, '0, '0, 1'b0, '0, '0);
    add_step(OP_WRITE, csr_pkg::CSR_MSTATUS, '0, 1'b0, '0, '0);
    add_step(OP_WAIT, '0, '0, 1'b0, '0, '0);
    add_step(OP_WRITE, csr_pkg::CSR_MSTATUS, 64'h8, 1'b0, '0, '0);
    add_step(OP_WAIT, '0, '0, 1'b0, '0, '0);
    add_step(OP_WRITE, csr_pkg::CSR_MIE, 64'h800, 1'b0, '0, '0);
    add_step(OP_WAIT, '0, '0, 1'b0, '0, '0);
    add_step(OP_IRQ, '0, 64'h4, 1'b0, '0, '0);
    add_step(OP_WAIT, '0, '0, 1'b0, '0, '0);
    add_step(OP_WAIT, '0, '0, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MIP, '0, 1'b0, '0, '0);
    add_step(OP_IRQ, '0, '0, 1'b0, '0, '0);
    add_step(OP_WAIT, '0, '0, 1'b0, '0, '0);
    add_step(OP_WAIT, '0, '0, 1'b0, '0, '0);
    // Cycle counter, free running and written
    add_step(OP_READ, csr_pkg::CSR_MCYCLE, '0, 1'b0, '0, '0);
    repeat (5) add_step(OP_WAIT, '0, '0, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MCYCLE, '0, 1'b0, '0, '0);
    add_step(OP_WRITE, csr_pkg::CSR_MCYCLE, 64'h1000, 1'b0, '0, '0);
    add_step(OP_READ, csr_pkg::CSR_MCYCLE, '0, 1'b0, '0, '0);

    limit = steps.size() * 4 + 16 + 50;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    foreach (steps[i]) begin
      drive_step(steps[i]);
      #10;
      check_step(i, steps[i]);
      @(negedge clk);
    end

    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, i_csr_unit.i_csr_unit_checker.fails);
    if (errors == 0 && i_csr_unit.i_csr_unit_checker.fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+source
source/csr_pkg.sv
source/irq_sync.sv
source/trap_ctrl.sv
source/csr_file.sv
source/csr_unit.sv
verification/csr_unit_checker.sv
verification/csr_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= sim passed
SOURCES   := $(wildcard source/*.sv source/*.svh verification/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
